// File: mem_subsystem.f
rtl/mem_status_pkg.sv
rtl/mem_port_pkg.sv
rtl/word_memory.sv
rtl/region_decoder.sv
rtl/error_collector.sv
rtl/mem_subsystem.sv
dv/mem_checker.sv
dv/mem_subsystem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= mem_subsystem.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/mem_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb
    import mem_status_pkg::*;
    import mem_port_pkg::*;
();

    localparam int BANK_WORDS   = 1024;
    localparam int HALF_PERIOD  = 50;   // 100 ns clock
    localparam int RESET_CYCLES = 4;
    localparam int DONE_WAIT    = 4;    // cycles allowed for done

    // one row of stimulus and expected results
    typedef struct packed {
        logic        rd_en;
        logic [31:0] rd_addr;
        logic        wr_en;
        logic [31:0] wr_addr;
        logic        clear;         // err_clear during the done cycle
        mem_status_e exp_status;
        logic        err_chk;       // look at err after the entry
        mem_status_e err_code;      // success means empty record
    } entry_t;

    logic        clk;
    logic        rst;
    rd_req_t     rd;
    wr_req_t     wr;
    logic        err_clear;
    logic [31:0] rd_data;
    mem_status_e status;
    logic        done;
    err_rec_t    err;
    int          checker_errors;
    int          failed_entries;
    int          budget;            // watchdog limit in cycles
    entry_t      entries[$];

    mem_subsystem #(
        .BANK_WORDS (BANK_WORDS)
    ) i_mem_subsystem (
        .clk       (clk),
        .rst       (rst),
        .rd        (rd),
        .wr        (wr),
        .err_clear (err_clear),
        .rd_data   (rd_data),
        .status    (status),
        .done      (done),
        .err       (err)
    );

    mem_checker #(
        .BANK_WORDS (BANK_WORDS)
    ) i_mem_checker (
        .clk         (clk),
        .rst         (rst),
        .rd          (rd),
        .wr          (wr),
        .err_clear   (err_clear),
        .rd_data     (rd_data),
        .status      (status),
        .done        (done),
        .err         (err),
        .error_count (checker_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // two cycles per entry plus reset and slack
    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        $display("timeout: run still going after %0d cycles", budget);
        $display("Testbench failed");
        $finish;
    end

    task automatic add_entry(input logic rd_en, input logic [31:0] rd_addr,
                             input logic wr_en, input logic [31:0] wr_addr,
                             input logic clear, input mem_status_e exp_status,
                             input logic err_chk, input mem_status_e err_code);
        entry_t e;
        e.rd_en      = rd_en;
        e.rd_addr    = rd_addr;
        e.wr_en      = wr_en;
        e.wr_addr    = wr_addr;
        e.clear      = clear;
        e.exp_status = exp_status;
        e.err_chk    = err_chk;
        e.err_code   = err_code;
        entries.push_back(e);
    endtask

    // bank 1 starts at 0x10000, word 1024 is 0x1000, upper bits from 0x20000
    task automatic build_entries();
        // rd_en rd_addr wr_en wr_addr clear status err_chk err_code
        add_entry(1'b0, 32'h0, 1'b1, 32'h0, 1'b0, success, 1'b1, success);
        add_entry(1'b0, 32'h0, 1'b1, 32'h4, 1'b0, success, 1'b0, success);
        add_entry(1'b0, 32'h0, 1'b1, 32'h10000, 1'b0, success, 1'b0, success);
        add_entry(1'b0, 32'h0, 1'b1, 32'h10ffc, 1'b0, success, 1'b0, success);
        add_entry(1'b1, 32'h0, 1'b0, 32'h0, 1'b0, success, 1'b0, success);
        add_entry(1'b1, 32'h10ffc, 1'b0, 32'h0, 1'b0, success, 1'b0, success);
        // both ports, different banks
        add_entry(1'b1, 32'h4, 1'b1, 32'h10000, 1'b0, success, 1'b0, success);
        add_entry(1'b1, 32'h10000, 1'b1, 32'h8, 1'b0, success, 1'b1, success);
        // same bank conflict, then the word is unchanged
        add_entry(1'b1, 32'h4, 1'b1, 32'h8, 1'b0, read_write, 1'b1, read_write);
        add_entry(1'b1, 32'h8, 1'b0, 32'h0, 1'b0, success, 1'b1, read_write);
        // range and alignment faults leave the first record alone
        add_entry(1'b1, 32'h1000, 1'b0, 32'h0, 1'b0, out_of_bounds, 1'b1, read_write);
        add_entry(1'b0, 32'h0, 1'b1, 32'h20000, 1'b0, out_of_bounds, 1'b1, read_write);
        add_entry(1'b1, 32'h10002, 1'b0, 32'h0, 1'b0, alignment, 1'b1, read_write);
        add_entry(1'b0, 32'h0, 1'b1, 32'h1001, 1'b0, out_of_bounds, 1'b0, read_write);
        add_entry(1'b1, 32'h11ffe, 1'b0, 32'h0, 1'b0, out_of_bounds, 1'b0, read_write);
        // clear, record again, clear together with a new error
        add_entry(1'b1, 32'h0, 1'b0, 32'h0, 1'b1, success, 1'b1, success);
        add_entry(1'b0, 32'h0, 1'b1, 32'h10006, 1'b0, alignment, 1'b1, alignment);
        add_entry(1'b1, 32'h10ffc, 1'b1, 32'h40000, 1'b1, out_of_bounds, 1'b1, out_of_bounds);
        add_entry(1'b1, 32'h20004, 1'b1, 32'h10ffd, 1'b0, out_of_bounds, 1'b1, out_of_bounds);
        add_entry(1'b1, 32'h10ffc, 1'b1, 32'h10ffc, 1'b0, read_write, 1'b1, out_of_bounds);
        add_entry(1'b1, 32'h0, 1'b1, 32'h4, 1'b1, read_write, 1'b1, read_write);
        add_entry(1'b1, 32'h4, 1'b0, 32'h0, 1'b0, success, 1'b1, read_write);
        add_entry(1'b1, 32'h10000, 1'b1, 32'h0, 1'b0, success, 1'b0, read_write);
    endtask

    initial begin
        entry_t e;
        int     i;
        int     waited;
        int     errors_before;
        logic   entry_ok;
        void'($urandom(84214));
        rst            = 1'b1;
        rd             = '0;
        wr             = '0;
        err_clear      = 1'b0;
        failed_entries = 0;
        budget         = 0;
        build_entries();
        budget = RESET_CYCLES + 2 * entries.size() + 20;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        for (i = 0; i < entries.size(); i++) begin
            e             = entries[i];
            errors_before = checker_errors;
            entry_ok      = 1'b1;
            rd.en         = e.rd_en;
            rd.addr.raw   = e.rd_addr;
            wr.en         = e.wr_en;
            wr.addr.raw   = e.wr_addr;
            wr.data       = e.wr_en ? $urandom : '0;
            waited        = 1;
            @(negedge clk);
            while (!done && (waited < DONE_WAIT)) begin
                @(negedge clk);
                waited++;
            end
            rd        = '0;     // back to idle in the done cycle
            wr        = '0;
            err_clear = e.clear;
            if (!done) begin
                $display("entry %0d: no done pulse within %0d cycles", i, DONE_WAIT);
                entry_ok = 1'b0;
            end else if (status !== e.exp_status) begin
                $display("error: status expected 0x%h got 0x%h", e.exp_status, status);
                entry_ok = 1'b0;
            end
            @(negedge clk);     // record settles on the edge after done
            err_clear = 1'b0;
            if (e.err_chk && (err.valid !== (e.err_code != success))) begin
                $display("error: err.valid expected 0x%h got 0x%h",
                         e.err_code != success, err.valid);
                entry_ok = 1'b0;
            end
            if (e.err_chk && (err.code !== e.err_code)) begin
                $display("error: err.code expected 0x%h got 0x%h", e.err_code, err.code);
                entry_ok = 1'b0;
            end
            if (checker_errors != errors_before) begin
                entry_ok = 1'b0;
            end
            if (!entry_ok) begin
                failed_entries++;
            end
            $display("entry %0d: rd %b %h wr %b %h expect %s: %s", i, e.rd_en, e.rd_addr,
                     e.wr_en, e.wr_addr, e.exp_status.name(), entry_ok ? "ok" : "failed");
        end

        repeat (2) @(negedge clk);  // let the checker see the last record
        $display("entries %0d, failed %0d, checker errors %0d",
                 entries.size(), failed_entries, checker_errors);
        if ((failed_entries == 0) && (checker_errors == 0)) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_checker
    import mem_status_pkg::*;
    import mem_port_pkg::*;
#(
    parameter int BANK_WORDS = 1024     // must match the DUT
) (
    input  logic        clk,
    input  logic        rst,
    input  rd_req_t     rd,
    input  wr_req_t     wr,
    input  logic        err_clear,
    input  logic [31:0] rd_data,
    input  mem_status_e status,
    input  logic        done,
    input  err_rec_t    err,
    output int          error_count
);

    localparam int IDX_W = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

    logic [31:0] shadow [2][BANK_WORDS];    // expected contents per bank
    logic        exp_done;
    mem_status_e exp_status;                // holds between accesses
    logic [31:0] exp_rd_data;               // last clean read
    err_rec_t    exp_err;
    mem_status_e pend_code;                 // merged result of the access in flight
    logic [31:0] pend_addr;                 // address blamed for it

    // conflict > bounds > alignment > success
    function automatic int severity(input mem_status_e code);
        case (code)
            read_write:    return 3;
            out_of_bounds: return 2;
            alignment:     return 1;
            default:       return 0;
        endcase
    endfunction

    // one port on its own, bounds checked before alignment
    function automatic mem_status_e port_code(input mem_addr_u a);
        if (a.f.upper != '0) begin
            return out_of_bounds;       // outside both banks
        end
        if (int'(a.f.word_idx) >= BANK_WORDS) begin
            return out_of_bounds;       // past the end of the bank
        end
        if (a.f.offset != 2'b00) begin
            return alignment;
        end
        return success;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected 0x%h got 0x%h at %0t", name, expected, actual, $time);
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        mem_status_e rd_code;
        mem_status_e wr_code;
        logic        conflict;
        if (rst) begin
            exp_done    = 1'b0;
            exp_status  = success;
            exp_rd_data = '0;
            exp_err     = '0;
            pend_code   = success;
            pend_addr   = '0;
            error_count = 0;
        end else begin
            // outputs belonging to the access taken on the previous edge
            compare_value("done", 32'(exp_done), 32'(done));
            compare_value("status", 32'(exp_status), 32'(status));
            compare_value("rd_data", exp_rd_data, rd_data);
            compare_value("err.valid", 32'(exp_err.valid), 32'(err.valid));
            compare_value("err.code", 32'(exp_err.code), 32'(err.code));
            compare_value("err.addr", exp_err.addr, err.addr);

            // sticky record moves on the edge closing the done cycle
            if (exp_done && (pend_code != success) && (!exp_err.valid || err_clear)) begin
                exp_err.valid = 1'b1;
                exp_err.code  = pend_code;
                exp_err.addr  = pend_addr;
            end else if (err_clear) begin
                exp_err = '0;           // emptied
            end

            rd_code  = rd.en ? port_code(rd.addr) : success;
            wr_code  = wr.en ? port_code(wr.addr) : success;
            conflict = rd.en && wr.en && (rd.addr.f.upper == '0) && (wr.addr.f.upper == '0)
                       && (rd.addr.f.bank_sel == wr.addr.f.bank_sel);
            if (conflict) begin
                rd_code = read_write;   // bank blames both ports
                wr_code = read_write;
            end

            exp_done = rd.en || wr.en;
            if (severity(rd_code) >= severity(wr_code)) begin  // tie goes to read
                pend_code = rd_code;
                pend_addr = rd.addr.raw;
            end else begin
                pend_code = wr_code;
                pend_addr = wr.addr.raw;
            end
            if (exp_done) begin
                exp_status = pend_code;
            end

            // read sees contents before this edge's write
            if (rd.en && (rd_code == success)) begin
                exp_rd_data = shadow[rd.addr.f.bank_sel][rd.addr.f.word_idx[IDX_W-1:0]];
            end
            if (wr.en && (wr_code == success)) begin
                shadow[wr.addr.f.bank_sel][wr.addr.f.word_idx[IDX_W-1:0]] = wr.data;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem
    import mem_status_pkg::*;
    import mem_port_pkg::*;
#(
    parameter int BANK_WORDS = 1024     // per bank
) (
    input  logic        clk,
    input  logic        rst,
    input  rd_req_t     rd,
    input  wr_req_t     wr,
    input  logic        err_clear,
    output logic [31:0] rd_data,
    output mem_status_e status,
    output logic        done,
    output err_rec_t    err
);

    rd_req_t [1:0]     bank_rd;         // decoder to banks
    wr_req_t [1:0]     bank_wr;
    logic [1:0][31:0]  bank_rd_data;    // banks back to decoder
    mem_status_e [1:0] bank_status;     // banks to collector
    logic [1:0]        bank_done;
    logic              rd_range_fault;
    logic              wr_range_fault;

    region_decoder #(
        .BANK_WORDS (BANK_WORDS)
    ) i_region_decoder (
        .clk            (clk),
        .rst            (rst),
        .rd             (rd),
        .wr             (wr),
        .bank_rd        (bank_rd),
        .bank_wr        (bank_wr),
        .bank_rd_data   (bank_rd_data),
        .rd_data        (rd_data),
        .rd_range_fault (rd_range_fault),
        .wr_range_fault (wr_range_fault)
    );

    // bank n holds addresses with bank_sel == n
    for (genvar n = 0; n < 2; n++) begin : g_bank
        word_memory #(
            .BANK_WORDS (BANK_WORDS)
        ) i_word_memory (
            .clk     (clk),
            .rst     (rst),
            .rd      (bank_rd[n]),
            .wr      (bank_wr[n]),
            .rd_data (bank_rd_data[n]),
            .status  (bank_status[n]),
            .done    (bank_done[n])
        );
    end

    error_collector i_error_collector (
        .clk            (clk),
        .rst            (rst),
        .rd_en          (rd.en),
        .wr_en          (wr.en),
        .rd_range_fault (rd_range_fault),
        .wr_range_fault (wr_range_fault),
        .rd_addr        (rd.addr),
        .wr_addr        (wr.addr),
        .bank_status    (bank_status),
        .bank_done      (bank_done),
        .err_clear      (err_clear),
        .status         (status),
        .done           (done),
        .err            (err)
    );

endmodule

`default_nettype wire

// File: rtl/error_collector.sv
`timescale 1ns/1ps
`default_nettype none

module error_collector
    import mem_status_pkg::*;
    import mem_port_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rd_en,          // raw port strobes
    input  logic              wr_en,
    input  logic              rd_range_fault,
    input  logic              wr_range_fault,
    input  mem_addr_u         rd_addr,
    input  mem_addr_u         wr_addr,
    input  mem_status_e [1:0] bank_status,
    input  logic [1:0]        bank_done,
    input  logic              err_clear,
    output mem_status_e       status,
    output logic              done,
    output err_rec_t          err
);

    logic        rd_en_q;
    logic        wr_en_q;
    logic        rd_fault_q;
    logic        wr_fault_q;
    mem_addr_u   rd_addr_q;
    mem_addr_u   wr_addr_q;
    mem_status_e rd_code;       // what happened to the read port
    mem_status_e wr_code;       // and to the write port
    mem_status_e merged;
    mem_status_e status_q;      // last reported status
    logic        rd_wins;       // read port ranks at least as high

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en_q    <= 1'b0;
            wr_en_q    <= 1'b0;
            rd_fault_q <= 1'b0;
            wr_fault_q <= 1'b0;
        end else begin
            rd_en_q    <= rd_en;
            wr_en_q    <= wr_en;
            rd_fault_q <= rd_range_fault;
            wr_fault_q <= wr_range_fault;
        end
    end

    always_ff @(posedge clk) begin
        rd_addr_q <= rd_addr;   // lines up with the bank status
        wr_addr_q <= wr_addr;
    end

    // per-port code, the bank_sel bit says which bank served the port
    always_comb begin
        rd_code = success;
        wr_code = success;
        if (rd_fault_q) begin
            rd_code = out_of_bounds;
        end else if (rd_en_q && bank_done[rd_addr_q.f.bank_sel]) begin
            rd_code = bank_status[rd_addr_q.f.bank_sel];
        end
        if (wr_fault_q) begin
            wr_code = out_of_bounds;
        end else if (wr_en_q && bank_done[wr_addr_q.f.bank_sel]) begin
            wr_code = bank_status[wr_addr_q.f.bank_sel];
        end
    end

    assign rd_wins = status_rank(rd_code) >= status_rank(wr_code);  // ties go to read
    assign merged  = rd_wins ? rd_code : wr_code;
    assign done    = rd_fault_q || wr_fault_q || (|bank_done);
    assign status  = done ? merged : status_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            status_q <= success;
        end else begin
            status_q <= status;
        end
    end

    // first error sticks; a clear in the same cycle as a new error
    // makes room for that error
    always_ff @(posedge clk) begin
        if (rst) begin
            err <= '0;
        end else if (done && (merged != success) && (!err.valid || err_clear)) begin
            err.valid <= 1'b1;
            err.code  <= merged;
            err.addr  <= rd_wins ? rd_addr_q.raw : wr_addr_q.raw;
        end else if (err_clear) begin
            err <= '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/region_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module region_decoder
    import mem_port_pkg::*;
#(
    parameter int BANK_WORDS = 1024     // same value as the banks
) (
    input  logic             clk,
    input  logic             rst,
    input  rd_req_t          rd,
    input  wr_req_t          wr,
    output rd_req_t [1:0]    bank_rd,
    output wr_req_t [1:0]    bank_wr,
    input  logic [1:0][31:0] bank_rd_data,
    output logic [31:0]      rd_data,
    output logic             rd_range_fault,
    output logic             wr_range_fault
);

    localparam logic [14:0] WORD_LIMIT = 15'(BANK_WORDS);

    logic rd_hit;       // read goes to a bank
    logic wr_hit;       // write goes to a bank
    logic same_bank;    // write lands on the read's bank
    logic rd_clean;     // read the bank will actually serve
    logic rd_bank_q;    // bank whose read register drives rd_data

    // anything above the two banks is outside the region
    assign rd_range_fault = rd.en && (rd.addr.f.upper != '0);
    assign wr_range_fault = wr.en && (wr.addr.f.upper != '0);

    assign rd_hit = rd.en && !rd_range_fault;
    assign wr_hit = wr.en && !wr_range_fault;

    // address and data go to both banks, strobe only to the selected one
    always_comb begin
        for (int n = 0; n < 2; n++) begin
            bank_rd[n]    = rd;
            bank_rd[n].en = rd_hit && (rd.addr.f.bank_sel == 1'(n));
            bank_wr[n]    = wr;
            bank_wr[n].en = wr_hit && (wr.addr.f.bank_sel == 1'(n));
        end
    end

    assign same_bank = wr_hit && (wr.addr.f.bank_sel == rd.addr.f.bank_sel);

    // mirrors the bank's own read checks, so the select
    // moves only when that bank loads new read data
    assign rd_clean = rd_hit && !same_bank
                      && (rd.addr.f.offset == 2'b00)
                      && ({1'b0, rd.addr.f.word_idx} < WORD_LIMIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_bank_q <= 1'b0;          // bank 0 read register is zero out of reset
        end else if (rd_clean) begin
            rd_bank_q <= rd.addr.f.bank_sel;
        end
    end

    assign rd_data = bank_rd_data[rd_bank_q];   // valid the cycle after the read

endmodule

`default_nettype wire

// File: rtl/word_memory.sv
`timescale 1ns/1ps
`default_nettype none

module word_memory
    import mem_status_pkg::*;
    import mem_port_pkg::*;
#(
    parameter int BANK_WORDS = 1024     // words in this bank, up to 16384
) (
    input  logic        clk,
    input  logic        rst,
    input  rd_req_t     rd,
    input  wr_req_t     wr,
    output logic [31:0] rd_data,
    output mem_status_e status,
    output logic        done
);

    localparam int          IDX_W      = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;
    localparam logic [14:0] WORD_LIMIT = 15'(BANK_WORDS);  // one bit wider than word_idx

    logic [31:0] mem [BANK_WORDS];      // plain array, maps to block ram

    logic             rd_oob;
    logic             wr_oob;
    logic             rd_misaligned;
    logic             wr_misaligned;
    logic             rd_ok;
    logic             wr_ok;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    mem_status_e      check;            // result of this cycle's access

    assign rd_oob        = {1'b0, rd.addr.f.word_idx} >= WORD_LIMIT;
    assign wr_oob        = {1'b0, wr.addr.f.word_idx} >= WORD_LIMIT;
    assign rd_misaligned = rd.addr.f.offset != 2'b00;
    assign wr_misaligned = wr.addr.f.offset != 2'b00;
    assign rd_idx        = rd.addr.f.word_idx[IDX_W-1:0];  // only used once in range
    assign wr_idx        = wr.addr.f.word_idx[IDX_W-1:0];

    // prioritised checks, read side before write side at each level
    always_comb begin
        check = success;
        if (rd.en && wr.en) begin
            check = read_write;         // both ports on this bank
        end else if (rd.en && rd_oob) begin
            check = out_of_bounds;
        end else if (wr.en && wr_oob) begin
            check = out_of_bounds;
        end else if (rd.en && rd_misaligned) begin
            check = alignment;
        end else if (wr.en && wr_misaligned) begin
            check = alignment;
        end
    end

    // conflict already caught above, so at most one of these is set
    assign rd_ok = rd.en && (check == success);
    assign wr_ok = wr.en && (check == success);

    always_ff @(posedge clk) begin
        if (rst) begin
            status <= success;
            done   <= 1'b0;
        end else begin
            done <= rd.en || wr.en;     // one pulse per strobe
            if (rd.en || wr.en) begin
                status <= check;        // holds while idle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_idx] <= wr.data;
        end
    end

    // read register, starts at zero and only moves on a clean read
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rd_ok) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

// File: rtl/mem_port_pkg.sv
`default_nettype none

package mem_port_pkg;

    // read port request, 33 bits
    typedef struct packed {
        logic                    en;    // one-cycle strobe
        mem_status_pkg::mem_addr_u addr;
    } rd_req_t;

    // write port request, 65 bits
    typedef struct packed {
        logic                    en;    // one-cycle strobe
        mem_status_pkg::mem_addr_u addr;
        logic [31:0]             data;  // full word only
    } wr_req_t;

    // sticky record of the first failing access, 35 bits
    typedef struct packed {
        logic                      valid;
        mem_status_pkg::mem_status_e code;
        logic [31:0]               addr;   // raw byte address
    } err_rec_t;

endpackage

`default_nettype wire

// File: rtl/mem_status_pkg.sv
`default_nettype none

package mem_status_pkg;

    // per-access result code
    typedef enum logic [1:0] {
        success       = 2'b00,  // clean access
        read_write    = 2'b01,  // read and write hit one bank together
        out_of_bounds = 2'b10,  // word index past the bank, or upper bits set
        alignment     = 2'b11   // low two address bits nonzero
    } mem_status_e;

    // field view of a byte address with the msb field first
    typedef struct packed {
        logic [14:0] upper;     // must be zero
        logic        bank_sel;  // picks bank 0 or 1
        logic [13:0] word_idx;  // word inside the bank
        logic [1:0]  offset;    // byte offset, word access only
    } mem_addr_fields_t;

    // one address word read raw or by field
    typedef union packed {
        logic [31:0]      raw;
        mem_addr_fields_t f;
    } mem_addr_u;

    // higher rank wins when codes are merged
    function automatic logic [1:0] status_rank(input mem_status_e code);
        logic [1:0] rank;
        case (code)
            read_write:    rank = 2'd3;
            out_of_bounds: rank = 2'd2;
            alignment:     rank = 2'd1;
            default:       rank = 2'd0;  // success
        endcase
        return rank;
    endfunction

endpackage

`default_nettype wire
